/* common/demux_macros.svh */
/*
  Write demux parameters.
  Port count, ID tracking depth and bus widths.
*/
`ifndef DEMUX_MACROS_SVH
`define DEMUX_MACROS_SVH

// master ports and the select that picks one
`define DEMUX_NUM_PORTS  4
`define DEMUX_SEL_WIDTH  2

// full axi id and the low bits that get their own tracker entry
`define DEMUX_ID_WIDTH   4
`define DEMUX_LOOK_BITS  2

// bus widths
`define DEMUX_ADDR_WIDTH 32
`define DEMUX_DATA_WIDTH 32

// in-flight counters saturate at all ones
`define DEMUX_CNT_WIDTH  3

`endif

/* common/demux_pkg.sv */
/*
  Write demux types.
  Channel payloads, port bundles and the select and counter types.
*/
`include "demux_macros.svh"

package demux_pkg;

  // port select and in-flight count
  typedef logic [`DEMUX_SEL_WIDTH-1:0] sel_t;
  typedef logic [`DEMUX_CNT_WIDTH-1:0] cnt_t;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  typedef struct packed {
    logic [`DEMUX_ID_WIDTH-1:0]   id;
    logic [`DEMUX_ADDR_WIDTH-1:0] addr;
    // axi4 burst length, beats minus one
    logic [7:0]                   len;
  } aw_chan_t;

  typedef struct packed {
    logic [`DEMUX_DATA_WIDTH-1:0]   data;
    logic [`DEMUX_DATA_WIDTH/8-1:0] strb;
    logic                           last;
  } w_chan_t;

  typedef struct packed {
    logic [`DEMUX_ID_WIDTH-1:0] id;
    logic [1:0]                 resp;
  } b_chan_t;

  // ----------------------------------------
  // payload plus valid
  // ----------------------------------------
  typedef struct packed {aw_chan_t aw; logic valid;} aw_port_t;
  typedef struct packed {w_chan_t w; logic valid;} w_port_t;
  typedef struct packed {b_chan_t b; logic valid;} b_port_t;

endpackage

/* write_route/aw_lock_fsm.sv */
/*
  AW admission and valid lock.
  Forwards the slave AW to one master once the W, ID and counter
  checks allow it, then holds that valid until the master takes it.
*/
`timescale 1ns/10ps
`include "demux_macros.svh"

module aw_lock_fsm (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               aw_valid_i,
  input  demux_pkg::sel_t                    aw_sel_i,
  input  logic [`DEMUX_ID_WIDTH-1:0]         aw_id_i,
  input  logic [`DEMUX_NUM_PORTS-1:0]        mst_aw_ready_i,
  input  logic                               w_busy_i,
  input  demux_pkg::sel_t                    w_sel_i,
  input  logic                               id_occupied_i,
  input  demux_pkg::sel_t                    id_sel_i,
  input  logic                               id_full_i,
  input  logic                               cnt_full_i,
  output logic [`DEMUX_NUM_PORTS-1:0]        mst_aw_valid_o,
  output logic                               aw_ready_o,
  output logic                               aw_push_o
);
  import demux_pkg::*;

  typedef enum logic {st_idle, st_locked} state_e;

  state_e                      state_q, state_d;
  // port of the last admitted aw
  sel_t                        push_sel_q;
  // admission terms
  logic                        w_conflict, id_conflict, stall;
  // where the forwarded valid goes this cycle
  logic                        fwd;
  sel_t                        route_sel;

  // open w bursts pin new aws to their port
  assign w_conflict  = w_busy_i && (w_sel_i != aw_sel_i);
  // same tracked id still open elsewhere
  assign id_conflict = id_occupied_i && (id_sel_i != aw_sel_i);
  assign stall = id_full_i || cnt_full_i || w_conflict || id_conflict;

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_comb begin
    state_d   = state_q;
    fwd       = 1'b0;
    route_sel = aw_sel_i;
    aw_push_o = 1'b0;
    case (state_q)
      st_idle: begin
        if (aw_valid_i && !stall) begin
          fwd       = 1'b1;
          // push once on the first forwarded cycle
          aw_push_o = 1'b1;
          if (!mst_aw_ready_i[aw_sel_i]) begin
            state_d = st_locked;
          end
        end
      end
      st_locked: begin
        // valid stays on the admitted port whatever the checks say now
        fwd       = 1'b1;
        route_sel = push_sel_q;
        if (mst_aw_ready_i[push_sel_q]) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  // one-hot valid toward the masters
  always_comb begin
    mst_aw_valid_o = '0;
    mst_aw_valid_o[route_sel] = fwd;
  end
  assign aw_ready_o = fwd && mst_aw_ready_i[route_sel];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // captured on every admission
  always_ff @(posedge clk_i) begin
    if (aw_push_o) begin
      push_sel_q <= aw_sel_i;
    end
  end

endmodule

/* write_route/w_route_counter.sv */
/*
  W channel steering.
  Counts open bursts and routes W beats to the port of the
  newest admitted AW, which all open bursts share.
*/
`timescale 1ns/10ps
`include "demux_macros.svh"

module w_route_counter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        aw_push_i,
  input  demux_pkg::sel_t             aw_sel_i,
  input  demux_pkg::w_port_t          w_i,
  input  logic [`DEMUX_NUM_PORTS-1:0] mst_w_ready_i,
  output logic [`DEMUX_NUM_PORTS-1:0] mst_w_valid_o,
  output logic                        w_ready_o,
  output logic                        w_busy_o,
  output demux_pkg::sel_t             w_sel_o,
  output logic                        cnt_full_o
);
  import demux_pkg::*;

  cnt_t open_q;
  sel_t sel_q;
  logic route_valid;
  logic last_done;

  assign w_busy_o   = |open_q;
  assign cnt_full_o = &open_q;
  // with nothing open the aw being pushed now decides the port
  assign w_sel_o     = w_busy_o ? sel_q : aw_sel_i;
  assign route_valid = w_busy_o || aw_push_i;

  // w handshake through the selected port only
  always_comb begin
    mst_w_valid_o = '0;
    w_ready_o     = 1'b0;
    if (route_valid) begin
      mst_w_valid_o[w_sel_o] = w_i.valid;
      w_ready_o              = mst_w_ready_i[w_sel_o];
    end
  end

  // a burst closes when its last beat transfers
  assign last_done = w_i.valid && w_ready_o && w_i.w.last;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      open_q <= '0;
    end else begin
      case ({aw_push_i, last_done})
        2'b10:   open_q <= open_q + cnt_t'(1);
        2'b01:   open_q <= open_q - cnt_t'(1);
        default: open_q <= open_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_push_i) begin
      sel_q <= aw_sel_i;
    end
  end

endmodule

/* source/id_track_table.sv */
/*
  Per-ID write tracker.
  One in-flight counter and stored port select for each value of
  the low ID bits, with a lookup for the AW being presented.
*/
`timescale 1ns/10ps
`include "demux_macros.svh"

module id_track_table (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // lookup of the presented aw
  input  logic [`DEMUX_LOOK_BITS-1:0] lookup_id_i,
  output logic                        occupied_o,
  output demux_pkg::sel_t             sel_o,
  output logic                        full_o,
  // admission
  input  logic                        push_i,
  input  logic [`DEMUX_LOOK_BITS-1:0] push_id_i,
  input  demux_pkg::sel_t             push_sel_i,
  // accepted b response
  input  logic                        pop_i,
  input  logic [`DEMUX_LOOK_BITS-1:0] pop_id_i
);
  import demux_pkg::*;

  localparam int unsigned NUM_ENTRIES = 1 << `DEMUX_LOOK_BITS;

  cnt_t                   cnt_q [NUM_ENTRIES];
  sel_t                   sel_q [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] push_en;
  logic [NUM_ENTRIES-1:0] pop_en;
  logic [NUM_ENTRIES-1:0] entry_full;

  // ----------------------------------------
  // entry decode
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      push_en[i]    = push_i && (push_id_i == `DEMUX_LOOK_BITS'(i));
      pop_en[i]     = pop_i && (pop_id_i == `DEMUX_LOOK_BITS'(i));
      entry_full[i] = &cnt_q[i];
    end
  end

  // ----------------------------------------
  // counters
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        // push and pop of one id together leave it unchanged
        case ({push_en[i], pop_en[i]})
          2'b10:   cnt_q[i] <= cnt_q[i] + cnt_t'(1);
          2'b01:   cnt_q[i] <= cnt_q[i] - cnt_t'(1);
          default: cnt_q[i] <= cnt_q[i];
        endcase
      end
    end
  end

  // port of the latest push per id
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

  assign occupied_o = |cnt_q[lookup_id_i];
  assign sel_o      = sel_q[lookup_id_i];
  // any saturated entry blocks new admissions
  assign full_o     = |entry_full;

endmodule

/* source/b_resp_arbiter.sv */
/*
  B response merge.
  Round-robin over the master B channels, grant held while the
  slave has not taken the response.
*/
`timescale 1ns/10ps
`include "demux_macros.svh"

module b_resp_arbiter (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  demux_pkg::b_port_t [`DEMUX_NUM_PORTS-1:0]  mst_b_i,
  input  logic                                       b_ready_i,
  output logic               [`DEMUX_NUM_PORTS-1:0]  mst_b_ready_o,
  output demux_pkg::b_port_t                         b_o,
  output logic                                       pop_o,
  output logic               [`DEMUX_LOOK_BITS-1:0]  pop_id_o
);
  import demux_pkg::*;

  // last winner and the held grant
  sel_t last_q;
  logic lock_q;
  sel_t lock_idx_q;
  // search result and the grant in use
  sel_t rr_idx;
  sel_t cand;
  sel_t gnt_idx;

  // ----------------------------------------
  // round-robin search
  // ----------------------------------------
  // scan from farthest to nearest so the port right after the last
  // winner is assigned last and wins, sel_t wraps around the ports
  always_comb begin
    rr_idx = last_q;
    for (int k = `DEMUX_NUM_PORTS; k >= 1; k--) begin
      cand = last_q + sel_t'(k);
      if (mst_b_i[cand].valid) begin
        rr_idx = cand;
      end
    end
  end

  assign gnt_idx = lock_q ? lock_idx_q : rr_idx;

  // winner payload or all zero
  always_comb begin
    b_o = '0;
    if (mst_b_i[gnt_idx].valid) begin
      b_o = mst_b_i[gnt_idx];
    end
  end

  always_comb begin
    mst_b_ready_o = '0;
    mst_b_ready_o[gnt_idx] = b_o.valid && b_ready_i;
  end

  assign pop_o    = b_o.valid && b_ready_i;
  assign pop_id_o = b_o.b.id[`DEMUX_LOOK_BITS-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
      last_q <= '0;
    end else if (b_o.valid) begin
      if (b_ready_i) begin
        lock_q <= 1'b0;
        last_q <= gnt_idx;
      end else begin
        lock_q <= 1'b1;
      end
    end
  end

  // stalled grant kept for the next cycle
  always_ff @(posedge clk_i) begin
    if (b_o.valid && !b_ready_i) begin
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

/* source/demux_top.sv */
/*
  One-to-four AXI write demux.
  AW goes to the selected master, W follows in AW order,
  B responses are merged back by a round-robin arbiter.
*/
`timescale 1ns/10ps
`include "demux_macros.svh"

module demux_top (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  // slave port
  input  demux_pkg::aw_port_t                         aw_i,
  input  demux_pkg::sel_t                             aw_sel_i,
  output logic                                        aw_ready_o,
  input  demux_pkg::w_port_t                          w_i,
  output logic                                        w_ready_o,
  output demux_pkg::b_port_t                          b_o,
  input  logic                                        b_ready_i,
  // master ports
  output demux_pkg::aw_port_t [`DEMUX_NUM_PORTS-1:0]  mst_aw_o,
  input  logic                [`DEMUX_NUM_PORTS-1:0]  mst_aw_ready_i,
  output demux_pkg::w_port_t  [`DEMUX_NUM_PORTS-1:0]  mst_w_o,
  input  logic                [`DEMUX_NUM_PORTS-1:0]  mst_w_ready_i,
  input  demux_pkg::b_port_t  [`DEMUX_NUM_PORTS-1:0]  mst_b_i,
  output logic                [`DEMUX_NUM_PORTS-1:0]  mst_b_ready_o
);
  import demux_pkg::*;

  // per-port valids from the route blocks
  logic [`DEMUX_NUM_PORTS-1:0] mst_aw_valid;
  logic [`DEMUX_NUM_PORTS-1:0] mst_w_valid;
  // w steering state seen by the aw admission
  logic                        w_busy;
  logic                        cnt_full;
  sel_t                        w_sel;
  // id lookup for the presented aw
  logic                        id_occupied;
  logic                        id_full;
  sel_t                        id_sel;
  logic [`DEMUX_LOOK_BITS-1:0] aw_look_id;
  // admission and response events
  logic                        aw_push;
  logic                        b_pop;
  logic [`DEMUX_LOOK_BITS-1:0] b_pop_id;

  // only the low id bits are tracked
  assign aw_look_id = aw_i.aw.id[`DEMUX_LOOK_BITS-1:0];

  aw_lock_fsm u_aw_fsm (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .aw_valid_i     (aw_i.valid),
    .aw_sel_i       (aw_sel_i),
    .aw_id_i        (aw_i.aw.id),
    .mst_aw_ready_i (mst_aw_ready_i),
    .w_busy_i       (w_busy),
    .w_sel_i        (w_sel),
    .id_occupied_i  (id_occupied),
    .id_sel_i       (id_sel),
    .id_full_i      (id_full),
    .cnt_full_i     (cnt_full),
    .mst_aw_valid_o (mst_aw_valid),
    .aw_ready_o     (aw_ready_o),
    .aw_push_o      (aw_push)
  );

  w_route_counter u_w_route (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .aw_push_i     (aw_push),
    .aw_sel_i      (aw_sel_i),
    .w_i           (w_i),
    .mst_w_ready_i (mst_w_ready_i),
    .mst_w_valid_o (mst_w_valid),
    .w_ready_o     (w_ready_o),
    .w_busy_o      (w_busy),
    .w_sel_o       (w_sel),
    .cnt_full_o    (cnt_full)
  );

  id_track_table u_id_table (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .lookup_id_i (aw_look_id),
    .push_i      (aw_push),
    .push_id_i   (aw_look_id),
    .push_sel_i  (aw_sel_i),
    .pop_i       (b_pop),
    .pop_id_i    (b_pop_id),
    .occupied_o  (id_occupied),
    .sel_o       (id_sel),
    .full_o      (id_full)
  );

  b_resp_arbiter u_b_arb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_b_i       (mst_b_i),
    .b_ready_i     (b_ready_i),
    .mst_b_ready_o (mst_b_ready_o),
    .b_o           (b_o),
    .pop_o         (b_pop),
    .pop_id_o      (b_pop_id)
  );

  // payloads fan out to every master, only the valids are steered
  for (genvar i = 0; i < `DEMUX_NUM_PORTS; i++) begin : gen_mst_fanout
    assign mst_aw_o[i].aw    = aw_i.aw;
    assign mst_aw_o[i].valid = mst_aw_valid[i];
    assign mst_w_o[i].w      = w_i.w;
    assign mst_w_o[i].valid  = mst_w_valid[i];
  end

endmodule

/* test/demux_assertions.sv */
/*
  Write demux checker.
  Concurrent assertions on AW routing and lock, AW and W ordering
  and the B merge, with its own record of open bursts and IDs.
*/
`timescale 1ns/10ps
`include "demux_macros.svh"

module demux_assertions (
  input logic                                        clk_i,
  input logic                                        reset_i,
  input demux_pkg::aw_port_t                         aw_i,
  input demux_pkg::sel_t                             aw_sel_i,
  input logic                                        aw_ready_o,
  input demux_pkg::w_port_t                          w_i,
  input logic                                        w_ready_o,
  input demux_pkg::b_port_t                          b_o,
  input logic                                        b_ready_i,
  input demux_pkg::aw_port_t [`DEMUX_NUM_PORTS-1:0]  mst_aw_o,
  input logic                [`DEMUX_NUM_PORTS-1:0]  mst_aw_ready_i,
  input demux_pkg::w_port_t  [`DEMUX_NUM_PORTS-1:0]  mst_w_o,
  input logic                [`DEMUX_NUM_PORTS-1:0]  mst_w_ready_i,
  input demux_pkg::b_port_t  [`DEMUX_NUM_PORTS-1:0]  mst_b_i,
  input logic                [`DEMUX_NUM_PORTS-1:0]  mst_b_ready_o
);
  import demux_pkg::*;

  localparam int NP = `DEMUX_NUM_PORTS;
  localparam int NE = 1 << `DEMUX_LOOK_BITS;

  // raised by any failing assertion, watched by the testbench
  bit                          err_seen = 1'b0;
  logic [NP-1:0]               aw_v;
  logic [NP-1:0]               w_v;
  logic [NP-1:0]               b_v;
  sel_t                        b_idx;
  // aw shown without ready in the previous cycle
  logic                        aw_held_q;
  logic                        new_fwd;
  logic [`DEMUX_LOOK_BITS-1:0] aw_lid;
  logic [`DEMUX_LOOK_BITS-1:0] b_lid;
  // reference state: open bursts, open writes per tracked id
  int                          open_cnt;
  sel_t                        open_port;
  int                          id_cnt [NE];
  sel_t                        id_port [NE];
  int                          aw_total;
  int                          b_total;
  logic                        aw_id_open;
  sel_t                        aw_id_port;
  logic                        b_id_open;
  logic                        w_route;
  sel_t                        w_port;
  logic                        w_last_xfer;
  logic                        b_xfer;

  task automatic flag_failure(input string what);
    $error("%s", what);
    err_seen = 1'b1;
  endtask

  always_comb begin
    b_idx = '0;
    for (int i = 0; i < NP; i++) begin
      aw_v[i] = mst_aw_o[i].valid;
      w_v[i]  = mst_w_o[i].valid;
      b_v[i]  = mst_b_i[i].valid;
      if (mst_b_ready_o[i]) begin
        b_idx = sel_t'(i);
      end
    end
  end

  // first cycle an aw shows up at a master
  assign new_fwd     = (aw_v != '0) && !aw_held_q;
  assign aw_lid      = aw_i.aw.id[`DEMUX_LOOK_BITS-1:0];
  assign b_lid       = b_o.b.id[`DEMUX_LOOK_BITS-1:0];
  assign aw_id_open  = id_cnt[aw_lid] != 0;
  assign aw_id_port  = id_port[aw_lid];
  assign b_id_open   = id_cnt[b_lid] != 0;
  assign b_xfer      = b_o.valid && b_ready_i;
  assign w_last_xfer = w_i.valid && w_ready_o && w_i.w.last;
  // w may use an open burst or the aw forwarded right now
  assign w_route     = (open_cnt != 0) || new_fwd;
  assign w_port      = (open_cnt != 0) ? open_port : aw_sel_i;

  // ----------------------------------------
  // reference state
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_held_q <= 1'b0;
      open_cnt  <= 0;
      aw_total  <= 0;
      b_total   <= 0;
      for (int i = 0; i < NE; i++) begin
        id_cnt[i] <= 0;
      end
    end else begin
      aw_held_q <= (aw_v != '0) && !aw_ready_o;
      open_cnt  <= open_cnt + int'(new_fwd) - int'(w_last_xfer);
      // all open bursts share one port
      if (new_fwd) begin
        open_port       <= aw_sel_i;
        id_port[aw_lid] <= aw_sel_i;
      end
      if (aw_i.valid && aw_ready_o) begin
        aw_total <= aw_total + 1;
      end
      if (b_xfer) begin
        b_total <= b_total + 1;
      end
      for (int i = 0; i < NE; i++) begin
        id_cnt[i] <= id_cnt[i] + int'(new_fwd && (aw_lid == `DEMUX_LOOK_BITS'(i)))
                   - int'(b_xfer && (b_lid == `DEMUX_LOOK_BITS'(i)));
      end
    end
  end

  // ----------------------------------------
  // aw channel
  // ----------------------------------------
  a_aw_route: assert property (@(posedge clk_i) disable iff (reset_i)
    ((aw_v != '0) || aw_ready_o) |-> aw_i.valid && (aw_v == (NP'(1) << aw_sel_i))
      && (mst_aw_o[aw_sel_i].aw == aw_i.aw) && (aw_ready_o == mst_aw_ready_i[aw_sel_i]))
    else flag_failure("AW valid is not on the selected port or its payload differs");

  a_aw_lock: assert property (@(posedge clk_i) disable iff (reset_i)
    ((aw_v != '0) && !aw_ready_o) |=> $stable(aw_v))
    else flag_failure("AW valid dropped or moved before the master took it");

  // new aws keep to the port of open bursts and of open writes with their id
  a_aw_order: assert property (@(posedge clk_i) disable iff (reset_i)
    new_fwd |-> ((open_cnt == 0) || (open_port == aw_sel_i))
      && (!aw_id_open || (aw_id_port == aw_sel_i)))
    else flag_failure("AW forwarded past open W bursts or an open ID on another port");

  // ----------------------------------------
  // w channel
  // ----------------------------------------
  a_w_route: assert property (@(posedge clk_i) disable iff (reset_i)
    (w_i.valid && w_route) |-> (w_v == (NP'(1) << w_port))
      && (mst_w_o[w_port].w == w_i.w) && (w_ready_o == mst_w_ready_i[w_port]))
    else flag_failure("W beat not routed to the port of the oldest open burst");

  a_w_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !(w_i.valid && w_route) |-> (w_v == '0) && (w_route || !w_ready_o))
    else flag_failure("W valid or ready shown with no burst to route to");

  // ----------------------------------------
  // b channel
  // ----------------------------------------
  a_b_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    b_o.valid == (b_v != '0))
    else flag_failure("B output valid does not follow the master responses");

  a_b_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    b_xfer |-> $onehot(mst_b_ready_o) && mst_b_i[b_idx].valid && (mst_b_i[b_idx] == b_o))
    else flag_failure("B taken but not from exactly one matching master");

  a_b_noready: assert property (@(posedge clk_i) disable iff (reset_i)
    !b_xfer |-> (mst_b_ready_o == '0))
    else flag_failure("master B ready given while the slave takes no response");

  a_b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (b_o.valid && !b_ready_i) |=> $stable(b_o))
    else flag_failure("B output changed before the slave took it");

  // no response without a write still waiting for one
  a_b_once: assert property (@(posedge clk_i) disable iff (reset_i)
    b_xfer |-> b_id_open && (b_total < aw_total))
    else flag_failure("B response with no open write to answer");

endmodule

bind demux_top demux_assertions u_chk (.*);

/* test/demux_tb.sv */
/*
  Write demux testbench.
  Random writes on the slave port, master models with random
  readies and delayed B responses, checked by the bound checker.
*/
`timescale 1ns/10ps
`include "demux_macros.svh"

module demux_tb;
  import demux_pkg::*;

  localparam int NP         = `DEMUX_NUM_PORTS;
  localparam int NUM_WRITES = 200;
  // about 2.5 beats per write at 3/4 valid and 3/4 ready is ~900 cycles,
  // port changes drain the w path first, so several times that as margin
  localparam int MAX_CYCLES = 6000;

  logic                       clk_i;
  logic                       reset_i;
  aw_port_t                   aw_i;
  sel_t                       aw_sel_i;
  logic                       aw_ready_o;
  w_port_t                    w_i;
  logic                       w_ready_o;
  b_port_t                    b_o;
  logic                       b_ready_i;
  aw_port_t [NP-1:0]          mst_aw_o;
  logic     [NP-1:0]          mst_aw_ready_i;
  w_port_t  [NP-1:0]          mst_w_o;
  logic     [NP-1:0]          mst_w_ready_i;
  b_port_t  [NP-1:0]          mst_b_i;
  logic     [NP-1:0]          mst_b_ready_o;

  // stimulus bookkeeping
  int                         aw_issued;
  int                         b_seen;
  int                         cycles = 0;
  logic [7:0]                 beat;
  // burst lengths in aw order, for the w driver
  logic [7:0]                 w_len_q [$];
  // ids each master still owes a response for
  logic [`DEMUX_ID_WIDTH-1:0] b_pend_q [NP][$];
  // handshakes that happen at the coming rising edge
  logic                       aw_fire;
  logic                       w_fire;
  logic                       b_fire;
  logic [NP-1:0]              maw_fire;
  logic [NP-1:0]              mb_fire;

  demux_top DUT (.*);

  always #4 clk_i = ~clk_i;

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------
  task automatic sample_fires();
    aw_fire = aw_i.valid && aw_ready_o;
    w_fire  = w_i.valid && w_ready_o;
    b_fire  = b_o.valid && b_ready_i;
    for (int p = 0; p < NP; p++) begin
      maw_fire[p] = mst_aw_o[p].valid && mst_aw_ready_i[p];
      mb_fire[p]  = mst_b_i[p].valid && mst_b_ready_o[p];
    end
  endtask

  task automatic apply_fires();
    for (int p = 0; p < NP; p++) begin
      // master keeps the id to answer later
      if (maw_fire[p]) begin
        b_pend_q[p].push_back(mst_aw_o[p].aw.id);
      end
      if (mb_fire[p]) begin
        void'(b_pend_q[p].pop_front());
        mst_b_i[p] = '0;
      end
    end
    if (aw_fire) begin
      aw_i.valid = 1'b0;
    end
    if (w_fire) begin
      if (w_i.w.last) begin
        void'(w_len_q.pop_front());
        beat = '0;
      end else begin
        beat = beat + 8'd1;
      end
      w_i.valid = 1'b0;
    end
    if (b_fire) begin
      b_seen++;
    end
  endtask

  task automatic drive_slave();
    if (!aw_i.valid && (aw_issued < NUM_WRITES) && ($urandom_range(3) != 0)) begin
      aw_i.aw.id   = `DEMUX_ID_WIDTH'($urandom());
      aw_i.aw.addr = $urandom();
      aw_i.aw.len  = 8'($urandom_range(3));
      aw_sel_i     = sel_t'($urandom_range(NP - 1));
      aw_i.valid   = 1'b1;
      w_len_q.push_back(aw_i.aw.len);
      aw_issued++;
    end
    // beats may run ahead of their aw, the demux holds them back
    if (!w_i.valid && (w_len_q.size() != 0) && ($urandom_range(3) != 0)) begin
      w_i.w.data = $urandom();
      w_i.w.strb = '1;
      w_i.w.last = (beat == w_len_q[0]);
      w_i.valid  = 1'b1;
    end
    b_ready_i = ($urandom_range(3) != 0);
  endtask

  task automatic drive_masters();
    for (int p = 0; p < NP; p++) begin
      mst_aw_ready_i[p] = ($urandom_range(3) != 0);
      mst_w_ready_i[p]  = ($urandom_range(3) != 0);
      // responses come back in order after a random wait
      if (!mst_b_i[p].valid && (b_pend_q[p].size() != 0) && ($urandom_range(2) == 0)) begin
        mst_b_i[p].b.id   = b_pend_q[p][0];
        mst_b_i[p].b.resp = 2'($urandom_range(3));
        mst_b_i[p].valid  = 1'b1;
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : run_stimulus
    int pending;
    void'($urandom(96407));
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    aw_i           = '0;
    aw_sel_i       = '0;
    w_i            = '0;
    b_ready_i      = 1'b0;
    mst_aw_ready_i = '0;
    mst_w_ready_i  = '0;
    mst_b_i        = '0;
    aw_issued      = 0;
    b_seen         = 0;
    beat           = '0;
    aw_fire        = 1'b0;
    w_fire         = 1'b0;
    b_fire         = 1'b0;
    maw_fire       = '0;
    mb_fire        = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    while (b_seen < NUM_WRITES) begin
      drive_slave();
      drive_masters();
      // settle before reading the handshakes
      #1;
      sample_fires();
      @(negedge clk_i);
      apply_fires();
    end
    pending = 0;
    for (int p = 0; p < NP; p++) begin
      pending += b_pend_q[p].size();
    end
    if ((pending != 0) || DUT.u_chk.err_seen) begin
      if (pending != 0) begin
        $display("Error: pending_b 0x%0h, expected 0x0", pending);
      end
      $display("TESTBENCH FAILED");
      $fatal(1, "run ended with a failed check");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

  // checker flag and cycle limit
  always @(negedge clk_i) begin : watch_run
    cycles = cycles + 1;
    if (DUT.u_chk.err_seen) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "the bound checker reported a failed assertion");
    end else if (cycles > MAX_CYCLES) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout after %0d cycles, only %0d of %0d responses came back",
             MAX_CYCLES, b_seen, NUM_WRITES);
    end
  end

endmodule

/* project.f */
+incdir+common
common/demux_pkg.sv
write_route/aw_lock_fsm.sv
write_route/w_route_counter.sv
source/id_track_table.sv
source/b_resp_arbiter.sv
source/demux_top.sv
test/demux_assertions.sv
test/demux_tb.sv
